//--- logic/vgen_macros.svh
// raster sizes are tiny simulation values; change them together, H_TOTAL and V_TOTAL must be the sums
`ifndef VGEN_MACROS_SVH
`define VGEN_MACROS_SVH

// horizontal timing in pixels, front porch first, visible area last
`define VGEN_H_VISIBLE          32
`define VGEN_H_FRONT            4
`define VGEN_H_SYNC             4
`define VGEN_H_BACK             8
`define VGEN_H_TOTAL            48

// vertical timing in lines, visible area first
`define VGEN_V_VISIBLE          8
`define VGEN_V_FRONT            1
`define VGEN_V_SYNC             2
`define VGEN_V_BACK             3
`define VGEN_V_TOTAL            14

// counters to displayed pixel
`define VGEN_PIXEL_LAT          2

// register numbers on the 6-bit register port
`define VGEN_XR_VID_CTRL        6'h00
`define VGEN_XR_VID_LEFT        6'h04
`define VGEN_XR_VID_RIGHT       6'h05
`define VGEN_XR_SCANLINE        6'h08
`define VGEN_XR_VID_HSIZE       6'h0A
`define VGEN_XR_VID_VSIZE       6'h0B
`define VGEN_XR_PA_GFX_CTRL     6'h10
`define VGEN_XR_PA_DISP_ADDR    6'h12
`define VGEN_XR_PA_LINE_LEN     6'h13

// dark grey, so a running but unconfigured generator is visible
`define VGEN_BORDER_RESET       8'h08

`endif

//--- logic/vgen_pkg.sv
// counter widths follow the raster macros; left and right edges share the h counter width
`default_nettype none

`include "vgen_macros.svh"

package vgen_pkg;

    typedef logic [15:0] word_t;                            // register and vram word
    typedef logic [7:0]  color_t;                           // palette index

    typedef logic [$clog2(`VGEN_H_TOTAL)-1:0] hres_t;
    typedef logic [$clog2(`VGEN_V_TOTAL)-1:0] vres_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       h_visible;
        logic       v_visible;
    } sync_t;

    typedef struct packed {
        color_t     border;                                 // shown outside the window
        hres_t      left;                                   // first column inside
        hres_t      right;                                  // first column outside
    } vid_cfg_t;

    typedef struct packed {
        logic       blank;                                  // playfield off, no vram reads
        color_t     colorbase;                              // xor'd with each pixel index
        word_t      start_addr;                             // first word of the frame
        word_t      line_len;                               // words from line to line
    } pf_cfg_t;

    // VID_CTRL layout
    typedef struct packed {
        color_t     border;
        logic [3:0] rsvd;
        logic [3:0] intr;                                   // one-shot interrupt bits
    } vid_ctrl_t;

    // PA_GFX_CTRL layout
    typedef struct packed {
        color_t     colorbase;
        logic       blank;
        logic [6:0] rsvd;
    } gfx_ctrl_t;

    typedef union packed {
        word_t      word;
        vid_ctrl_t  vid_ctrl;
        gfx_ctrl_t  gfx_ctrl;
    } reg_word_u;

endpackage

`default_nettype wire

//--- logic/video_timing.sv
// all outputs registered and mutually aligned; both counters restart at 0 after reset, line 0 visible
`default_nettype none
`timescale 1ns/10ps

`include "vgen_macros.svh"

module video_timing (
    input  logic            clk,
    input  logic            reset_i,
    output vgen_pkg::sync_t sync_o,
    output vgen_pkg::hres_t h_count_o,
    output vgen_pkg::vres_t v_count_o,
    output logic            end_of_line_o,
    output logic            end_of_frame_o,
    output logic            end_of_visible_o
);
    import vgen_pkg::*;

    localparam hres_t H_LAST      = hres_t'(`VGEN_H_TOTAL - 1);
    localparam hres_t H_VIS_START = hres_t'(`VGEN_H_TOTAL - `VGEN_H_VISIBLE);
    localparam hres_t H_SYNC_ON   = hres_t'(`VGEN_H_FRONT);
    localparam hres_t H_SYNC_OFF  = hres_t'(`VGEN_H_FRONT + `VGEN_H_SYNC);
    localparam vres_t V_LAST      = vres_t'(`VGEN_V_TOTAL - 1);
    localparam vres_t V_VIS_LAST  = vres_t'(`VGEN_V_VISIBLE - 1);
    localparam vres_t V_VIS_END   = vres_t'(`VGEN_V_VISIBLE);
    localparam vres_t V_SYNC_ON   = vres_t'(`VGEN_V_VISIBLE + `VGEN_V_FRONT);
    localparam vres_t V_SYNC_OFF  = vres_t'(`VGEN_V_VISIBLE + `VGEN_V_FRONT + `VGEN_V_SYNC);

    hres_t h_next;
    vres_t v_next;

    // levels for a given raster position
    function automatic sync_t raster_sync(input hres_t h, input vres_t v);
        sync_t s;
        s.hsync     = (h >= H_SYNC_ON) && (h < H_SYNC_OFF);
        s.vsync     = (v >= V_SYNC_ON) && (v < V_SYNC_OFF);
        s.h_visible = (h >= H_VIS_START);
        s.v_visible = (v < V_VIS_END);
        return s;
    endfunction

    always_comb begin
        h_next = (h_count_o == H_LAST) ? '0 : h_count_o + 1'b1;
        v_next = v_count_o;
        if (h_count_o == H_LAST) begin
            v_next = (v_count_o == V_LAST) ? '0 : v_count_o + 1'b1;
        end
    end

    // levels and pulses are decoded from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o        <= '0;
            v_count_o        <= '0;
            sync_o           <= raster_sync('0, '0);
            end_of_line_o    <= 1'b0;
            end_of_frame_o   <= 1'b0;
            end_of_visible_o <= 1'b0;
        end else begin
            h_count_o        <= h_next;
            v_count_o        <= v_next;
            sync_o           <= raster_sync(h_next, v_next);
            end_of_line_o    <= (h_next == H_LAST);
            end_of_frame_o   <= (h_next == H_LAST) && (v_next == V_LAST);
            end_of_visible_o <= (h_next == H_LAST) && (v_next == V_VIS_LAST);  // vblank start
        end
    end

endmodule

`default_nettype wire

//--- logic/video_regs.sv
// plain write strobe, readback one cycle after reg_num_i; unlisted registers read 0, intr_o is a one-cycle pulse
`default_nettype none
`timescale 1ns/10ps

`include "vgen_macros.svh"

module video_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  logic [5:0]          reg_num_i,
    input  vgen_pkg::word_t     reg_data_i,
    output vgen_pkg::word_t     reg_data_o,
    input  vgen_pkg::vres_t     v_count_i,
    input  logic                end_of_visible_i,
    output vgen_pkg::vid_cfg_t  vid_cfg_o,
    output vgen_pkg::pf_cfg_t   pf_cfg_o,
    output logic [3:0]          intr_o
);
    import vgen_pkg::*;

    reg_word_u  wr_word;                                    // write data, seen through either view
    reg_word_u  rd_word;                                    // readback before the output register
    logic [3:0] vblank_intr;

    assign wr_word     = reg_data_i;
    assign vblank_intr = {end_of_visible_i, 3'b000};        // bit 3 doubles as vblank interrupt

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_cfg_o.border     <= `VGEN_BORDER_RESET;
            vid_cfg_o.left       <= '0;
            vid_cfg_o.right      <= hres_t'(`VGEN_H_VISIBLE);
            pf_cfg_o.blank       <= 1'b1;                   // playfield starts blanked
            pf_cfg_o.colorbase   <= '0;
            pf_cfg_o.start_addr  <= '0;
            pf_cfg_o.line_len    <= word_t'(`VGEN_H_VISIBLE / 2);
            intr_o               <= '0;
        end else begin
            intr_o <= vblank_intr;
            if (reg_wr_i) begin
                case (reg_num_i)
                    `VGEN_XR_VID_CTRL: begin
                        vid_cfg_o.border <= wr_word.vid_ctrl.border;
                        intr_o           <= wr_word.vid_ctrl.intr | vblank_intr;
                    end
                    `VGEN_XR_VID_LEFT: begin
                        vid_cfg_o.left <= hres_t'(wr_word.word);
                    end
                    `VGEN_XR_VID_RIGHT: begin
                        vid_cfg_o.right <= hres_t'(wr_word.word);
                    end
                    `VGEN_XR_PA_GFX_CTRL: begin
                        pf_cfg_o.colorbase <= wr_word.gfx_ctrl.colorbase;
                        pf_cfg_o.blank     <= wr_word.gfx_ctrl.blank;
                    end
                    `VGEN_XR_PA_DISP_ADDR: begin
                        pf_cfg_o.start_addr <= wr_word.word;    // used from next frame
                    end
                    `VGEN_XR_PA_LINE_LEN: begin
                        pf_cfg_o.line_len <= wr_word.word;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // readback mux, unused bits stay 0
    always_comb begin
        rd_word = '0;
        case (reg_num_i)
            `VGEN_XR_VID_CTRL: begin
                rd_word.vid_ctrl.border = vid_cfg_o.border;
            end
            `VGEN_XR_VID_LEFT: begin
                rd_word.word = word_t'(vid_cfg_o.left);
            end
            `VGEN_XR_VID_RIGHT: begin
                rd_word.word = word_t'(vid_cfg_o.right);
            end
            `VGEN_XR_SCANLINE: begin
                rd_word.word = word_t'(v_count_i);
            end
            `VGEN_XR_VID_HSIZE: begin
                rd_word.word = word_t'(`VGEN_H_VISIBLE);
            end
            `VGEN_XR_VID_VSIZE: begin
                rd_word.word = word_t'(`VGEN_V_VISIBLE);
            end
            `VGEN_XR_PA_GFX_CTRL: begin
                rd_word.gfx_ctrl.colorbase = pf_cfg_o.colorbase;
                rd_word.gfx_ctrl.blank     = pf_cfg_o.blank;
            end
            `VGEN_XR_PA_DISP_ADDR: begin
                rd_word.word = pf_cfg_o.start_addr;
            end
            `VGEN_XR_PA_LINE_LEN: begin
                rd_word.word = pf_cfg_o.line_len;
            end
            default: begin
                rd_word.word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_word.word;
    end

endmodule

`default_nettype wire

//--- logic/bitmap_fetch.sv
// vram must return data exactly one cycle after vram_sel_o; no stall, 8 bpp only, two pixels per word
`default_nettype none
`timescale 1ns/10ps

`include "vgen_macros.svh"

module bitmap_fetch (
    input  logic                clk,
    input  logic                reset_i,
    input  vgen_pkg::sync_t     sync_i,
    input  vgen_pkg::hres_t     h_count_i,
    input  logic                end_of_line_i,
    input  logic                end_of_frame_i,
    input  vgen_pkg::vid_cfg_t  vid_cfg_i,
    input  vgen_pkg::pf_cfg_t   pf_cfg_i,
    output logic                vram_sel_o,
    output vgen_pkg::word_t     vram_addr_o,
    input  vgen_pkg::word_t     vram_data_i,
    output vgen_pkg::sync_t     sync_o,
    output vgen_pkg::color_t    color_index_o
);
    import vgen_pkg::*;

    localparam hres_t H_VIS_START = hres_t'(`VGEN_H_TOTAL - `VGEN_H_VISIBLE);

    hres_t  pix_x;                                          // visible column at the counters
    word_t  line_addr;                                      // first word of the current line
    logic   rd_d1;                                          // vram data valid this cycle
    hres_t  x_d1;
    color_t lo_q;                                           // odd pixel of the last word
    color_t pix_byte;
    logic   in_window;
    sync_t  sync_pipe [`VGEN_PIXEL_LAT];

    assign pix_x       = h_count_i - H_VIS_START;
    assign vram_sel_o  = sync_i.h_visible & sync_i.v_visible & ~pix_x[0] & ~pf_cfg_i.blank;
    assign vram_addr_o = line_addr + word_t'(pix_x[$bits(hres_t)-1:1]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
        end else if (end_of_frame_i) begin
            line_addr <= pf_cfg_i.start_addr;               // start applies per frame
        end else if (end_of_line_i && sync_i.v_visible) begin
            line_addr <= line_addr + pf_cfg_i.line_len;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_d1 <= 1'b0;
        end else begin
            rd_d1 <= vram_sel_o;
        end
    end

    // even pixel comes straight from vram, odd pixel from the saved low byte
    always_ff @(posedge clk) begin
        x_d1 <= pix_x;
        if (rd_d1) begin
            lo_q <= vram_data_i[7:0];
        end
    end

    assign pix_byte  = rd_d1 ? vram_data_i[15:8] : lo_q;
    assign in_window = (x_d1 >= vid_cfg_i.left) && (x_d1 < vid_cfg_i.right);

    always_ff @(posedge clk) begin
        if (in_window && !pf_cfg_i.blank) begin
            color_index_o <= pix_byte ^ pf_cfg_i.colorbase;
        end else begin
            color_index_o <= vid_cfg_i.border;              // border is not xor'd
        end
    end

    // sync travels with the two pixel stages
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `VGEN_PIXEL_LAT; i++) begin
                sync_pipe[i] <= '0;
            end
        end else begin
            sync_pipe[0] <= sync_i;
            for (int i = 1; i < `VGEN_PIXEL_LAT; i++) begin
                sync_pipe[i] <= sync_pipe[i-1];
            end
        end
    end

    assign sync_o = sync_pipe[`VGEN_PIXEL_LAT-1];

endmodule

`default_nettype wire

//--- logic/video_gen.sv
// single bitmap playfield; vram is read with fixed one-cycle latency and the register port has no handshake
`default_nettype none
`timescale 1ns/10ps

module video_gen (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  logic [5:0]          reg_num_i,
    input  vgen_pkg::word_t     reg_data_i,
    output vgen_pkg::word_t     reg_data_o,
    output logic [3:0]          intr_o,
    output logic                vram_sel_o,
    output vgen_pkg::word_t     vram_addr_o,
    input  vgen_pkg::word_t     vram_data_i,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                h_blank_o,
    output logic                v_blank_o,
    output logic                dv_de_o,
    output vgen_pkg::color_t    color_index_o
);
    import vgen_pkg::*;

    sync_t      raster_sync;                                // at the counters
    sync_t      pix_sync;                                   // aligned with color_index_o
    hres_t      h_count;
    vres_t      v_count;
    logic       end_of_line;
    logic       end_of_frame;
    logic       end_of_visible;
    vid_cfg_t   vid_cfg;
    pf_cfg_t    pf_cfg;

    video_timing timing_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .sync_o             (raster_sync),
        .h_count_o          (h_count),
        .v_count_o          (v_count),
        .end_of_line_o      (end_of_line),
        .end_of_frame_o     (end_of_frame),
        .end_of_visible_o   (end_of_visible)
    );

    video_regs regs_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .reg_wr_i           (reg_wr_i),
        .reg_num_i          (reg_num_i),
        .reg_data_i         (reg_data_i),
        .reg_data_o         (reg_data_o),
        .v_count_i          (v_count),
        .end_of_visible_i   (end_of_visible),
        .vid_cfg_o          (vid_cfg),
        .pf_cfg_o           (pf_cfg),
        .intr_o             (intr_o)
    );

    bitmap_fetch fetch_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .sync_i             (raster_sync),
        .h_count_i          (h_count),
        .end_of_line_i      (end_of_line),
        .end_of_frame_i     (end_of_frame),
        .vid_cfg_i          (vid_cfg),
        .pf_cfg_i           (pf_cfg),
        .vram_sel_o         (vram_sel_o),
        .vram_addr_o        (vram_addr_o),
        .vram_data_i        (vram_data_i),
        .sync_o             (pix_sync),
        .color_index_o      (color_index_o)
    );

    assign hsync_o   = pix_sync.hsync;
    assign vsync_o   = pix_sync.vsync;
    assign h_blank_o = ~pix_sync.h_visible;
    assign v_blank_o = ~pix_sync.v_visible;
    assign dv_de_o   = pix_sync.h_visible & pix_sync.v_visible;

endmodule

`default_nettype wire

//--- dv/video_gen_sva.sv
// watches top-level outputs, plus the playfield blank flag taken from inside video_gen by the bind
`default_nettype none
`timescale 1ns/10ps

module video_gen_sva (
    input logic       clk,
    input logic       reset_i,
    input logic       dv_de_i,
    input logic       h_blank_i,
    input logic       v_blank_i,
    input logic       vram_sel_i,
    input logic       pf_blank_i,
    input logic [3:0] intr_i
);

    de_from_blanks: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i == (!h_blank_i && !v_blank_i))
        else $error("dv_de_o is not the AND of the inverted blanks");

    no_read_when_blank: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_i |-> !pf_blank_i)
        else $error("vram_sel_o high while the playfield is blanked");

    intr_clear_after_reset: assert property (@(posedge clk)
        reset_i |=> (intr_i == 4'h0))
        else $error("intr_o not clear in the cycle after reset");

endmodule

bind video_gen video_gen_sva sva_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .dv_de_i    (dv_de_o),
    .h_blank_i  (h_blank_o),
    .v_blank_i  (v_blank_o),
    .vram_sel_i (vram_sel_o),
    .pf_blank_i (pf_cfg.blank),
    .intr_i     (intr_o)
);

`default_nettype wire

//--- dv/video_gen_tb.sv
// config writes land only in vertical blank; vram model answers each select one cycle later
`default_nettype none
`timescale 1ns/10ps

`include "vgen_macros.svh"

module video_gen_tb;
    import vgen_pkg::*;

    localparam int FRAME       = `VGEN_H_TOTAL * `VGEN_V_TOTAL;  // cycles per frame
    localparam int FRAME_READS = `VGEN_V_VISIBLE * `VGEN_H_VISIBLE / 2;

    logic       clk;
    logic       reset_i;
    logic       reg_wr_i;
    logic [5:0] reg_num_i;
    word_t      reg_data_i;
    word_t      reg_data_o;
    logic [3:0] intr_o;
    logic       vram_sel_o;
    word_t      vram_addr_o;
    word_t      vram_data_i;
    logic       hsync_o;
    logic       vsync_o;
    logic       h_blank_o;
    logic       v_blank_o;
    logic       dv_de_o;
    color_t     color_index_o;

    word_t      vram [65536];
    vid_cfg_t   m_vid;                                      // expected configuration
    pf_cfg_t    m_pf;
    logic       rd_pending;
    word_t      rd_addr;
    logic       checking;                                   // pixel monitor armed
    int         pix_x;
    int         pix_y;
    int         reads;
    int         n_checks;
    int         n_errors;
    int         test_errors;                                // errors before the current test

    logic [5:0] all_regs [11] = '{`VGEN_XR_VID_CTRL, `VGEN_XR_VID_LEFT, `VGEN_XR_VID_RIGHT,
                                  `VGEN_XR_SCANLINE, `VGEN_XR_VID_HSIZE, `VGEN_XR_VID_VSIZE,
                                  `VGEN_XR_PA_GFX_CTRL, `VGEN_XR_PA_DISP_ADDR,
                                  `VGEN_XR_PA_LINE_LEN, 6'h01, 6'h3F};
    logic [5:0] stored_regs [6] = '{`VGEN_XR_VID_CTRL, `VGEN_XR_VID_LEFT, `VGEN_XR_VID_RIGHT,
                                    `VGEN_XR_PA_GFX_CTRL, `VGEN_XR_PA_DISP_ADDR,
                                    `VGEN_XR_PA_LINE_LEN};

    video_gen video_gen_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // vram answers the select seen in the previous cycle
    always @(posedge clk) begin
        #2;
        if (rd_pending) begin
            vram_data_i = vram[rd_addr];
        end
        rd_pending = vram_sel_o;
        rd_addr    = vram_addr_o;
    end

    // colour rule of one visible pixel, straight from the register fields
    function automatic color_t expect_pixel(input int x, input int y);
        word_t w;
        if (x < m_vid.left || x >= m_vid.right || m_pf.blank) begin
            return m_vid.border;
        end
        w = vram[word_t'(m_pf.start_addr + y * m_pf.line_len + x / 2)];
        return ((x % 2 == 0) ? w[15:8] : w[7:0]) ^ m_pf.colorbase;
    endfunction

    function automatic word_t expect_reg(input logic [5:0] num);
        case (num)
            `VGEN_XR_VID_CTRL:     return {m_vid.border, 8'h00};
            `VGEN_XR_VID_LEFT:     return word_t'(m_vid.left);
            `VGEN_XR_VID_RIGHT:    return word_t'(m_vid.right);
            `VGEN_XR_VID_HSIZE:    return word_t'(`VGEN_H_VISIBLE);
            `VGEN_XR_VID_VSIZE:    return word_t'(`VGEN_V_VISIBLE);
            `VGEN_XR_PA_GFX_CTRL:  return {m_pf.colorbase, m_pf.blank, 7'h00};
            `VGEN_XR_PA_DISP_ADDR: return m_pf.start_addr;
            `VGEN_XR_PA_LINE_LEN:  return m_pf.line_len;
            default:               return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // x counts dv_de cycles in the line, y counts lines with dv_de in the frame
    always @(posedge clk) begin
        #1;
        if (checking && vram_sel_o) begin
            reads++;
        end
        if (dv_de_o) begin
            if (checking) begin
                check_value($sformatf("pixel x=%0d y=%0d", pix_x, pix_y), color_index_o,
                            expect_pixel(pix_x, pix_y));
            end
            pix_x++;
        end else begin
            if (pix_x != 0) begin
                pix_y++;
            end
            pix_x = 0;
        end
        if (v_blank_o) begin
            pix_y = 0;                                      // after the line count, same cycle
        end
    end

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_blank(input logic level);
        int n;
        n = 0;
        while (v_blank_o !== level && n < 2 * FRAME) begin
            step(1);
            n++;
        end
        if (v_blank_o !== level) begin
            $display("timeout: v_blank_o did not become %0b within two frames", level);
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic write_reg(input logic [5:0] num, input word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        step(1);
        reg_wr_i = 1'b0;
        case (num)
            `VGEN_XR_VID_CTRL:     m_vid.border = data[15:8];
            `VGEN_XR_VID_LEFT:     m_vid.left = hres_t'(data);
            `VGEN_XR_VID_RIGHT:    m_vid.right = hres_t'(data);
            `VGEN_XR_PA_DISP_ADDR: m_pf.start_addr = data;
            `VGEN_XR_PA_LINE_LEN:  m_pf.line_len = data;
            `VGEN_XR_PA_GFX_CTRL: begin
                m_pf.colorbase = data[15:8];
                m_pf.blank     = data[7];
            end
            default: begin
            end
        endcase
    endtask

    task automatic read_reg(input logic [5:0] num, output word_t value);
        reg_num_i = num;
        step(1);
        value = reg_data_o;
    endtask

    task automatic check_regs();
        word_t got;
        foreach (all_regs[i]) begin
            read_reg(all_regs[i], got);
            if (all_regs[i] == `VGEN_XR_SCANLINE) begin
                check_value("SCANLINE below V_TOTAL", got < `VGEN_V_TOTAL, 1);
            end else begin
                check_value($sformatf("register %02h", all_regs[i]), got,
                            expect_reg(all_regs[i]));
            end
        end
    endtask

    // start of vertical blank, leaves a whole blank period for writes
    task automatic to_vblank();
        wait_blank(1'b0);
        wait_blank(1'b1);
    endtask

    task automatic check_frames(input int frames, input int reads_expected);
        wait_blank(1'b1);
        wait_blank(1'b0);
        reads    = 0;
        checking = 1'b1;
        for (int f = 0; f < frames; f++) begin
            wait_blank(1'b1);
            wait_blank(1'b0);
        end
        checking = 1'b0;
        check_value("vram reads", reads, reads_expected);
    endtask

    task automatic check_raster();
        int   de_run;
        int   hs_run;
        int   vs_run;
        int   hb_run;
        int   last_rise;
        int   lines;
        int   de_lines;
        int   hs_rises;
        int   vs_runs;
        logic hs_prev;
        wait_blank(1'b1);
        wait_blank(1'b0);
        de_run    = 0;
        hs_run    = 0;
        vs_run    = 0;
        hb_run    = 0;
        last_rise = -1;
        lines     = 0;
        de_lines  = 0;
        hs_rises  = 0;
        vs_runs   = 0;
        hs_prev   = hsync_o;
        for (int t = 0; t < 2 * FRAME; t++) begin
            if (dv_de_o) begin
                de_run++;
            end else if (de_run != 0) begin
                check_value("dv_de_o cycles per line", de_run, `VGEN_H_VISIBLE);
                lines++;
                de_lines++;
                de_run = 0;
            end
            if (hsync_o && !hs_prev && last_rise >= 0) begin
                check_value("hsync_o period", t - last_rise, `VGEN_H_TOTAL);
            end
            if (hsync_o && !hs_prev) begin
                last_rise = t;
                hs_rises++;
            end
            if (hsync_o) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_value("hsync_o width", hs_run, `VGEN_H_SYNC);
                hs_run = 0;
            end
            hs_prev = hsync_o;
            if (vsync_o) begin
                vs_run++;
            end else if (vs_run != 0) begin
                check_value("vsync_o width", vs_run, `VGEN_V_SYNC * `VGEN_H_TOTAL);
                vs_runs++;
                vs_run = 0;
            end
            if (!h_blank_o) begin
                hb_run++;
            end else if (hb_run != 0) begin
                check_value("h_blank_o low cycles per line", hb_run, `VGEN_H_VISIBLE);
                hb_run = 0;
            end
            if (v_blank_o && lines != 0) begin
                check_value("visible lines per frame", lines, `VGEN_V_VISIBLE);
                lines = 0;
            end
            step(1);
        end
        check_value("lines with dv_de_o in two frames", de_lines, 2 * `VGEN_V_VISIBLE);
        check_value("hsync_o pulses in two frames", hs_rises, 2 * `VGEN_V_TOTAL);
        check_value("vsync_o pulses in two frames", vs_runs, 2);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, n_errors - test_errors);
        test_errors = n_errors;
    endtask

    initial begin
        word_t      got;
        logic [3:0] nib;
        int         left;
        int         pulses;
        int         stray;
        void'($urandom(94));
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        vram_data_i = '0;
        rd_pending  = 1'b0;
        rd_addr     = '0;
        checking    = 1'b0;
        pix_x       = 0;
        pix_y       = 0;
        reads       = 0;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        m_vid = '{border: `VGEN_BORDER_RESET, left: 0, right: `VGEN_H_VISIBLE};
        m_pf  = '{blank: 1'b1, colorbase: 8'h00, start_addr: 16'h0000,
                  line_len: `VGEN_H_VISIBLE / 2};
        for (int a = 0; a < 65536; a++) begin
            vram[a] = word_t'($urandom);
        end
        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;

        check_regs();
        check_frames(1, 0);                                 // blanked, border only
        end_test("reset values");

        check_raster();
        end_test("raster shape");

        to_vblank();
        write_reg(`VGEN_XR_PA_DISP_ADDR, word_t'($urandom));
        write_reg(`VGEN_XR_PA_LINE_LEN, word_t'($urandom));
        write_reg(`VGEN_XR_PA_GFX_CTRL, {8'($urandom), 1'b0, 7'($urandom)});
        check_frames(2, 2 * FRAME_READS);
        end_test("bitmap display");

        to_vblank();
        left = $urandom % (`VGEN_H_VISIBLE + 1);
        write_reg(`VGEN_XR_VID_CTRL, {8'($urandom), 8'h00});
        write_reg(`VGEN_XR_VID_LEFT, word_t'(left));
        write_reg(`VGEN_XR_VID_RIGHT, word_t'(left + $urandom % (`VGEN_H_VISIBLE + 1 - left)));
        check_frames(1, FRAME_READS);
        end_test("border window");

        to_vblank();
        repeat (4) begin
            foreach (stored_regs[i]) begin
                write_reg(stored_regs[i], word_t'($urandom));
            end
            check_regs();
        end
        repeat (30) begin
            read_reg(`VGEN_XR_SCANLINE, got);
            check_value("SCANLINE below V_TOTAL", got < `VGEN_V_TOTAL, 1);
            step($urandom % 64);
        end
        end_test("readback");

        to_vblank();
        repeat (4) begin
            nib = 4'($urandom);
            write_reg(`VGEN_XR_VID_CTRL, {m_vid.border, 4'h0, nib});
            check_value("intr_o after VID_CTRL write", intr_o, nib);
            step(1);
            check_value("intr_o one cycle later", intr_o, 0);
        end
        pulses = 0;
        stray  = 0;
        repeat (3 * FRAME) begin
            step(1);
            pulses += intr_o[3];
            stray  += (intr_o[2:0] != 3'b000);
        end
        check_value("vblank interrupt pulses in three frames", pulses, 3);
        check_value("cycles with intr_o[2:0] set", stray, 0);
        end_test("interrupts");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/vgen_pkg.sv
logic/video_timing.sv
logic/video_regs.sv
logic/bitmap_fetch.sv
logic/video_gen.sv
dv/video_gen_sva.sv
dv/video_gen_tb.sv

//--- Bender.yml
package:
  name: video_gen

export_include_dirs:
  - logic

sources:
  - logic/vgen_pkg.sv
  - logic/video_timing.sv
  - logic/video_regs.sv
  - logic/bitmap_fetch.sv
  - logic/video_gen.sv
  - target: simulation
    files:
      - dv/video_gen_sva.sv
      - dv/video_gen_tb.sv
